//--- src/tc_geometry_pkg.sv
package tc_geometry_pkg;

   // Port field widths
   localparam int ADDR_SIZE  = 16;
   localparam int DATA_SIZE  = 32;
   localparam int WMASK_SIZE = 4;

   // Width of one write-mask lane
   localparam int BYTE_SIZE = DATA_SIZE / WMASK_SIZE;

   // Macro bank
   localparam int SELECT_SIZE = 4;
   localparam int MAX_CHIPS   = 2 ** SELECT_SIZE;

   // Behavioral macro only decodes the low address bits
   localparam int MACRO_ADDR_BITS = 8;
   localparam int MACRO_WORDS     = 2 ** MACRO_ADDR_BITS;

   // Command word layout
   //   port command = addr + din + csb + web + wmask
   //   command word = chip_sel + port0 + port1
   localparam int PORT_SIZE  = ADDR_SIZE + DATA_SIZE + 2 + WMASK_SIZE;
   localparam int TOTAL_SIZE = SELECT_SIZE + 2 * PORT_SIZE;

   // Sanity values
   //   PORT_SIZE  = 54
   //   TOTAL_SIZE = 112
   //   MAX_CHIPS  = 16
   //   MACRO_WORDS = 256

endpackage

//--- src/tc_cmd_pkg.sv
package tc_cmd_pkg;

   // One port's command, most significant field first
   typedef struct packed {
      logic [tc_geometry_pkg::ADDR_SIZE-1:0]  addr;
      logic [tc_geometry_pkg::DATA_SIZE-1:0]  din;
      // Active-low chip enable
      logic                                   csb;
      // Active-low write enable
      logic                                   web;
      // One bit per byte lane
      logic [tc_geometry_pkg::WMASK_SIZE-1:0] wmask;
   } port_cmd_t;

   // Full command register
   // Bit 111 (top of chip_sel) is the bit presented on scan_out
   typedef struct packed {
      logic [tc_geometry_pkg::SELECT_SIZE-1:0] chip_sel;
      port_cmd_t                               port0;
      port_cmd_t                               port1;
   } cmd_word_t;

   // Read data from both ports of one macro
   typedef struct packed {
      logic [tc_geometry_pkg::DATA_SIZE-1:0] dout0;
      logic [tc_geometry_pkg::DATA_SIZE-1:0] dout1;
   } rd_pair_t;

   // Port command width cross-check
   //   $bits(port_cmd_t) == PORT_SIZE
   //   $bits(cmd_word_t) == TOTAL_SIZE
   //   $bits(rd_pair_t)  == 2 * DATA_SIZE

endpackage

//--- src/sram_macro.sv
`timescale 1ns/10ps

module sram_macro (
   input  logic                  clk,
   // The csb fields of the port commands are not used here
   input  tc_cmd_pkg::port_cmd_t port0,
   input  tc_cmd_pkg::port_cmd_t port1,
   input  logic                  csb0,
   input  logic                  csb1,
   output tc_cmd_pkg::rd_pair_t  rd
);

   // Storage, starts cleared like a freshly initialized test array
   logic [tc_geometry_pkg::DATA_SIZE-1:0] mem [tc_geometry_pkg::MACRO_WORDS] =
      '{default: '0};

   // Registered read data per port
   logic [tc_geometry_pkg::DATA_SIZE-1:0] dout_q [2] = '{default: '0};

   // Both ports gathered so one loop serves them
   tc_cmd_pkg::port_cmd_t                       port [2];
   logic [1:0]                                  csb;
   logic [tc_geometry_pkg::MACRO_ADDR_BITS-1:0] word_addr [2];

   assign port[0] = port0;
   assign port[1] = port1;
   assign csb     = {csb1, csb0};

   // Upper address bits have no effect on this depth
   assign word_addr[0] = port0.addr[tc_geometry_pkg::MACRO_ADDR_BITS-1:0];
   assign word_addr[1] = port1.addr[tc_geometry_pkg::MACRO_ADDR_BITS-1:0];

   // Access on every edge where the port is selected
   always_ff @(posedge clk) begin
      for (int p = 0; p < 2; p++) begin
         if (!csb[p]) begin
            if (!port[p].web) begin
               // Masked write, only enabled byte lanes change
               for (int b = 0; b < tc_geometry_pkg::WMASK_SIZE; b++) begin
                  if (port[p].wmask[b]) begin
                     mem[word_addr[p]][b*tc_geometry_pkg::BYTE_SIZE +:
                                       tc_geometry_pkg::BYTE_SIZE] <=
                        port[p].din[b*tc_geometry_pkg::BYTE_SIZE +:
                                    tc_geometry_pkg::BYTE_SIZE];
                  end
               end
            end else begin
               // Read, dout holds until the next read on this port
               dout_q[p] <= mem[word_addr[p]];
            end
         end
      end
   end

   assign rd.dout0 = dout_q[0];
   assign rd.dout1 = dout_q[1];

   // Both ports writing one word in the same cycle leaves it undefined
   // on the real macro
   a_no_write_collision : assert property (
      @(posedge clk)
      !(!csb0 && !csb1 && !port0.web && !port1.web &&
        word_addr[0] == word_addr[1])
   ) else $error("sram_macro: both ports write word %0d in one cycle", word_addr[0]);

endmodule

//--- src/scan_cmd_reg.sv
`timescale 1ns/10ps

module scan_cmd_reg (
   input  logic                                  clk,
   input  logic                                  reset,
   input  logic                                  scan_en,
   input  logic                                  scan_in,
   input  logic                                  par_load,
   input  tc_cmd_pkg::cmd_word_t                 par_data,
   input  logic                                  capture,
   input  tc_cmd_pkg::rd_pair_t                  rd_sel,
   output tc_cmd_pkg::port_cmd_t                 port0,
   output tc_cmd_pkg::port_cmd_t                 port1,
   output logic [tc_geometry_pkg::MAX_CHIPS-1:0] csb0_vec,
   output logic [tc_geometry_pkg::MAX_CHIPS-1:0] csb1_vec,
   output logic                                  scan_out,
   output tc_cmd_pkg::cmd_word_t                 cmd
);

   tc_cmd_pkg::cmd_word_t                  cmd_q;
   logic [tc_geometry_pkg::TOTAL_SIZE-1:0] cmd_bits;
   logic [tc_geometry_pkg::TOTAL_SIZE-1:0] shifted;

   // Keeps every macro deselected from reset until the first command load.
   // The power-up value matches reset so nothing is selected before it.
   logic hold_q = 1'b1;

   // A command is being shifted or loaded this cycle
   logic loading;

   assign loading  = scan_en || par_load;
   assign cmd_bits = cmd_q;

   // Shift left, new bit enters at bit 0
   assign shifted = {cmd_bits[tc_geometry_pkg::TOTAL_SIZE-2:0], scan_in};

   // Priority: scan, then parallel load, then capture
   always_ff @(posedge clk) begin
      if (reset) begin
         cmd_q  <= '0;
         hold_q <= 1'b1;
      end else begin
         if (loading) begin
            hold_q <= 1'b0;
         end

         if (scan_en) begin
            cmd_q <= tc_cmd_pkg::cmd_word_t'(shifted);
         end else if (par_load) begin
            cmd_q <= par_data;
         end else if (capture) begin
            // Only the data fields take the read result
            cmd_q.port0.din <= rd_sel.dout0;
            cmd_q.port1.din <= rd_sel.dout1;
         end
      end
   end

   // Shared lines to every macro
   assign port0 = cmd_q.port0;
   assign port1 = cmd_q.port1;

   // One-cold select decode
   always_comb begin
      csb0_vec = '1;
      csb1_vec = '1;
      // A half-shifted command must never reach the memories
      if (!(hold_q || loading)) begin
         csb0_vec[cmd_q.chip_sel] = cmd_q.port0.csb;
         csb1_vec[cmd_q.chip_sel] = cmd_q.port1.csb;
      end
   end

   // Register contents straight out, no added delay
   assign scan_out = cmd_bits[tc_geometry_pkg::TOTAL_SIZE-1];
   assign cmd      = cmd_q;

   // Each select vector has at most one macro enabled
   a_one_cold_select : assert property (
      @(posedge clk) disable iff (reset)
      ($countones(~csb0_vec) <= 1) && ($countones(~csb1_vec) <= 1)
   ) else $error("scan_cmd_reg: illegal select vectors %h %h", csb0_vec, csb1_vec);

endmodule

//--- src/read_select.sv
`timescale 1ns/10ps

module read_select (
   input  logic                                  clk,
   input  logic                                  reset,
   input  logic [tc_geometry_pkg::MAX_CHIPS-1:0] csb0_vec,
   input  logic [tc_geometry_pkg::MAX_CHIPS-1:0] csb1_vec,
   input  tc_cmd_pkg::rd_pair_t                  rd_all [tc_geometry_pkg::MAX_CHIPS],
   output tc_cmd_pkg::rd_pair_t                  rd_sel
);

   logic                                    hit;
   logic [tc_geometry_pkg::SELECT_SIZE-1:0] hit_idx;
   logic [tc_geometry_pkg::SELECT_SIZE-1:0] idx_q;

   // Encode whichever chip is selected on either port
   always_comb begin
      hit     = 1'b0;
      hit_idx = '0;
      for (int i = 0; i < tc_geometry_pkg::MAX_CHIPS; i++) begin
         if (!csb0_vec[i] || !csb1_vec[i]) begin
            hit     = 1'b1;
            hit_idx = (tc_geometry_pkg::SELECT_SIZE)'(i);
         end
      end
   end

   // Remember the macro that was actually accessed
   always_ff @(posedge clk) begin
      if (reset) begin
         idx_q <= '0;
      end else if (hit) begin
         idx_q <= hit_idx;
      end
   end

   // Later chip_sel changes do not move this
   assign rd_sel = rd_all[idx_q];

   // Both ports active means they point at the same macro
   a_same_chip : assert property (
      @(posedge clk) disable iff (reset)
      (!(&csb0_vec) && !(&csb1_vec)) |-> (csb0_vec == csb1_vec)
   ) else $error("read_select: ports select different chips %h %h", csb0_vec, csb1_vec);

endmodule

//--- src/sram_testchip.sv
`timescale 1ns/10ps

module sram_testchip (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  scan_en,
   input  logic                  scan_in,
   input  logic                  par_load,
   input  tc_cmd_pkg::cmd_word_t par_data,
   input  logic                  capture,
   output logic                  scan_out,
   output tc_cmd_pkg::cmd_word_t par_data_out
);

   // Shared lines to every macro
   tc_cmd_pkg::port_cmd_t                 port0;
   tc_cmd_pkg::port_cmd_t                 port1;
   logic [tc_geometry_pkg::MAX_CHIPS-1:0] csb0_vec;
   logic [tc_geometry_pkg::MAX_CHIPS-1:0] csb1_vec;

   // Read data back from the bank
   tc_cmd_pkg::rd_pair_t rd_all [tc_geometry_pkg::MAX_CHIPS];
   tc_cmd_pkg::rd_pair_t rd_sel;

   scan_cmd_reg i_cmd_reg (
      .clk      (clk),
      .reset    (reset),
      .scan_en  (scan_en),
      .scan_in  (scan_in),
      .par_load (par_load),
      .par_data (par_data),
      .capture  (capture),
      .rd_sel   (rd_sel),
      .port0    (port0),
      .port1    (port1),
      .csb0_vec (csb0_vec),
      .csb1_vec (csb1_vec),
      .scan_out (scan_out),
      .cmd      (par_data_out)
   );

   // Sixteen macros, each with its own pair of selects
   for (genvar c = 0; c < tc_geometry_pkg::MAX_CHIPS; c++) begin : g_chip
      sram_macro i_macro (
         .clk   (clk),
         .port0 (port0),
         .port1 (port1),
         .csb0  (csb0_vec[c]),
         .csb1  (csb1_vec[c]),
         .rd    (rd_all[c])
      );
   end

   read_select i_read_select (
      .clk      (clk),
      .reset    (reset),
      .csb0_vec (csb0_vec),
      .csb1_vec (csb1_vec),
      .rd_all   (rd_all),
      .rd_sel   (rd_sel)
   );

endmodule

//--- tests/sram_testchip_tb.sv
`timescale 1ns/10ps

module sram_testchip_tb;

   localparam logic [31:0] SEED           = 32'hf4b3_c806;
   localparam int          N_WRITE_READ   = 20;
   localparam int          N_DUAL         = 8;
   localparam int          N_SCAN_LOAD    = 2;
   localparam int          N_SCAN_READ    = 6;
   localparam int          N_RESCAN       = 4;
   // About 60 operations of up to 230 cycles each, with margin
   localparam int          TIMEOUT_CYCLES = 20000;

   logic                  clk = 1'b0;
   logic                  reset;
   logic                  scan_en;
   logic                  scan_in;
   logic                  par_load;
   tc_cmd_pkg::cmd_word_t par_data;
   logic                  capture;
   logic                  scan_out;
   tc_cmd_pkg::cmd_word_t par_data_out;

   // Reference state of the bank
   logic [tc_geometry_pkg::DATA_SIZE-1:0]
      shadow [tc_geometry_pkg::MAX_CHIPS][tc_geometry_pkg::MACRO_WORDS] = '{default: '0};
   // Held read data per chip and port
   logic [tc_geometry_pkg::DATA_SIZE-1:0]
      last_dout [tc_geometry_pkg::MAX_CHIPS][2] = '{default: '0};
   int rem_chip = 0;

   // Expected register contents, as last loaded, scanned or captured
   tc_cmd_pkg::cmd_word_t cur_word = '0;

   // Words written by the write/read test, used as read targets later
   logic [tc_geometry_pkg::SELECT_SIZE-1:0]     wr_chip [$];
   logic [tc_geometry_pkg::MACRO_ADDR_BITS-1:0] wr_addr [$];

   // Requests from the stimulus to the compare process
   logic                  word_check_en = 1'b0;
   tc_cmd_pkg::cmd_word_t word_expected = '0;
   string                 word_what     = "";
   logic                  bit_check_en  = 1'b0;
   logic                  bit_expected  = 1'b0;
   string                 bit_what      = "";

   int cycle_count = 0;

   sram_testchip i_dut (
      .clk          (clk),
      .reset        (reset),
      .scan_en      (scan_en),
      .scan_in      (scan_in),
      .par_load     (par_load),
      .par_data     (par_data),
      .capture      (capture),
      .scan_out     (scan_out),
      .par_data_out (par_data_out)
   );

   initial begin
      forever #20 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Test failed");
         $fatal(1, "Timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
      end
   end

   task automatic check_word(input tc_cmd_pkg::cmd_word_t got,
                             input tc_cmd_pkg::cmd_word_t exp, input string what);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
         $display("Test failed");
         $fatal(1, "Stopped at the first mismatch");
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t: %s, got %b expected %b", $time, what, got, exp);
         $display("Test failed");
         $fatal(1, "Stopped at the first mismatch");
      end
   endtask

   // Outputs are compared at the falling edge, half a cycle after they change
   always @(negedge clk) begin
      if (word_check_en) begin
         check_word(par_data_out, word_expected, word_what);
      end
      if (bit_check_en) begin
         check_bit(scan_out, bit_expected, bit_what);
      end
   end

   // Applies one command to the reference bank and returns the word a
   // capture would then produce
   function automatic tc_cmd_pkg::cmd_word_t ref_capture(input tc_cmd_pkg::cmd_word_t c,
                                                         input logic active);
      tc_cmd_pkg::cmd_word_t                       exp;
      tc_cmd_pkg::port_cmd_t                       p [2];
      logic [tc_geometry_pkg::MACRO_ADDR_BITS-1:0] a;
      int                                          chip;
      p[0] = c.port0;
      p[1] = c.port1;
      chip = int'(c.chip_sel);
      for (int i = 0; i < 2; i++) begin
         // Upper address bits alias onto the same word
         a = p[i].addr[tc_geometry_pkg::MACRO_ADDR_BITS-1:0];
         if (active && !p[i].csb) begin
            rem_chip = chip;
            if (!p[i].web) begin
               for (int b = 0; b < tc_geometry_pkg::WMASK_SIZE; b++) begin
                  if (p[i].wmask[b]) begin
                     shadow[chip][a][b*tc_geometry_pkg::BYTE_SIZE +: tc_geometry_pkg::BYTE_SIZE] =
                        p[i].din[b*tc_geometry_pkg::BYTE_SIZE +: tc_geometry_pkg::BYTE_SIZE];
                  end
               end
            end else begin
               last_dout[chip][i] = shadow[chip][a];
            end
         end
      end
      exp           = c;
      exp.port0.din = last_dout[rem_chip][0];
      exp.port1.din = last_dout[rem_chip][1];
      return exp;
   endfunction

   function automatic tc_cmd_pkg::cmd_word_t random_word();
      logic [127:0] r;
      r = {$urandom, $urandom, $urandom, $urandom};
      return tc_cmd_pkg::cmd_word_t'(r[tc_geometry_pkg::TOTAL_SIZE-1:0]);
   endfunction

   function automatic tc_cmd_pkg::port_cmd_t set_access(input tc_cmd_pkg::port_cmd_t p,
                                                        input logic csb, input logic web);
      tc_cmd_pkg::port_cmd_t q;
      q     = p;
      q.csb = csb;
      q.web = web;
      return q;
   endfunction

   // Random address whose macro word differs from the given one
   function automatic logic [tc_geometry_pkg::ADDR_SIZE-1:0] other_addr(
      input logic [tc_geometry_pkg::ADDR_SIZE-1:0] a);
      logic [31:0] rnd;
      rnd    = $urandom;
      rnd[0] = 1'b1;
      return a ^ rnd[tc_geometry_pkg::ADDR_SIZE-1:0];
   endfunction

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge clk);
   endtask

   task automatic load_cmd(input tc_cmd_pkg::cmd_word_t w);
      @(posedge clk);
      par_load <= 1'b1;
      par_data <= w;
      @(posedge clk);
      par_load <= 1'b0;
      cur_word = w;
   endtask

   // Shifts one word in and leaves scan_en high behind the last bit
   task automatic shift_word(input tc_cmd_pkg::cmd_word_t w);
      logic [tc_geometry_pkg::TOTAL_SIZE-1:0] old_bits;
      logic [tc_geometry_pkg::TOTAL_SIZE-1:0] new_bits;
      old_bits = cur_word;
      new_bits = w;
      bit_what = "scan_out during shift";
      for (int i = tc_geometry_pkg::TOTAL_SIZE - 1; i >= 0; i--) begin
         @(posedge clk);
         scan_en      <= 1'b1;
         scan_in      <= new_bits[i];
         // Old contents leave most significant bit first
         bit_expected = old_bits[i];
         bit_check_en = 1'b1;
      end
      cur_word = w;
   endtask

   task automatic scan_cmd(input tc_cmd_pkg::cmd_word_t w);
      shift_word(w);
      @(posedge clk);
      scan_en       <= 1'b0;
      bit_check_en  = 1'b0;
      word_expected = w;
      word_what     = "register after scan";
      word_check_en = 1'b1;
      @(posedge clk);
      word_check_en = 1'b0;
   endtask

   task automatic capture_check(input tc_cmd_pkg::cmd_word_t exp, input string what);
      tc_cmd_pkg::cmd_word_t idle;
      idle           = exp;
      idle.port0.csb = 1'b1;
      idle.port1.csb = 1'b1;
      @(posedge clk);
      capture <= 1'b1;
      @(posedge clk);
      // Idle command right behind the capture, captured data is never written back
      capture       <= 1'b0;
      par_load      <= 1'b1;
      par_data      <= idle;
      word_expected = exp;
      word_what     = what;
      word_check_en = 1'b1;
      @(posedge clk);
      par_load      <= 1'b0;
      word_check_en = 1'b0;
      cur_word      = idle;
   endtask

   initial begin
      tc_cmd_pkg::cmd_word_t w;
      tc_cmd_pkg::cmd_word_t r;
      logic [31:0]           rnd;
      int                    k;

      void'($urandom(SEED));
      reset    <= 1'b1;
      scan_en  <= 1'b0;
      scan_in  <= 1'b0;
      par_load <= 1'b0;
      par_data <= '0;
      capture  <= 1'b0;

      repeat (16) @(posedge clk);
      reset <= 1'b0;

      // Cleared register, nothing selected
      word_expected = '0;
      word_what     = "register after reset";
      word_check_en = 1'b1;
      bit_expected  = 1'b0;
      bit_what      = "scan_out after reset";
      bit_check_en  = 1'b1;
      @(posedge clk);
      word_check_en = 1'b0;
      bit_check_en  = 1'b0;
      capture_check(ref_capture(cur_word, 1'b0), "capture after reset");

      // Parallel write, then read of the same word
      for (int n = 0; n < N_WRITE_READ; n++) begin
         w       = random_word();
         w.port0 = set_access(w.port0, 1'b0, 1'b0);
         w.port1 = set_access(w.port1, 1'b1, 1'b1);
         void'(ref_capture(w, 1'b1));
         load_cmd(w);
         wait_cycles(2);
         r          = random_word();
         r.chip_sel = w.chip_sel;
         r.port0.addr[tc_geometry_pkg::MACRO_ADDR_BITS-1:0] =
            w.port0.addr[tc_geometry_pkg::MACRO_ADDR_BITS-1:0];
         r.port0    = set_access(r.port0, 1'b0, 1'b1);
         r.port1    = set_access(r.port1, 1'b0, 1'b1);
         load_cmd(r);
         wait_cycles(2);
         capture_check(ref_capture(r, 1'b1), "parallel write then read");
         wr_chip.push_back(w.chip_sel);
         wr_addr.push_back(w.port0.addr[tc_geometry_pkg::MACRO_ADDR_BITS-1:0]);
      end

      // One port writes while the other reads another word of the same chip
      for (int n = 0; n < N_DUAL; n++) begin
         w            = random_word();
         w.port1.addr = other_addr(w.port0.addr);
         w.port0      = set_access(w.port0, 1'b0, 1'b0);
         w.port1      = set_access(w.port1, 1'b0, 1'b1);
         load_cmd(w);
         wait_cycles(2);
         capture_check(ref_capture(w, 1'b1), "port0 write with port1 read");
         w            = random_word();
         w.port0.addr = other_addr(w.port1.addr);
         w.port0      = set_access(w.port0, 1'b0, 1'b1);
         w.port1      = set_access(w.port1, 1'b0, 1'b0);
         load_cmd(w);
         wait_cycles(2);
         capture_check(ref_capture(w, 1'b1), "port1 write with port0 read");
      end

      // Scan load of idle words
      for (int n = 0; n < N_SCAN_LOAD; n++) begin
         w           = random_word();
         w.port0.csb = 1'b1;
         w.port1.csb = 1'b1;
         scan_cmd(w);
      end

      // A write command passes through the register mid-scan and must not land,
      // the read command behind it checks that the word is unchanged
      for (int n = 0; n < N_SCAN_READ; n++) begin
         k           = $urandom_range(wr_chip.size() - 1);
         r           = random_word();
         r.chip_sel  = wr_chip[k];
         r.port0.addr[tc_geometry_pkg::MACRO_ADDR_BITS-1:0] = wr_addr[k];
         r.port0.din   = ~shadow[wr_chip[k]][wr_addr[k]];
         r.port0.wmask = '1;
         r.port0     = set_access(r.port0, 1'b0, 1'b0);
         r.port1     = set_access(r.port1, 1'b1, 1'b1);
         w           = random_word();
         w.chip_sel  = wr_chip[k];
         w.port0.addr[tc_geometry_pkg::MACRO_ADDR_BITS-1:0] = wr_addr[k];
         w.port0     = set_access(w.port0, 1'b0, 1'b1);
         w.port1     = set_access(w.port1, 1'b1, 1'b1);
         shift_word(r);
         scan_cmd(w);
         wait_cycles(1);
         capture_check(ref_capture(w, 1'b1), "read after scan");
      end

      // Chip select moved before the capture
      for (int n = 0; n < N_RESCAN; n++) begin
         k          = $urandom_range(wr_chip.size() - 1);
         w          = random_word();
         w.chip_sel = wr_chip[k];
         w.port0.addr[tc_geometry_pkg::MACRO_ADDR_BITS-1:0] = wr_addr[k];
         w.port0    = set_access(w.port0, 1'b0, 1'b1);
         w.port1    = set_access(w.port1, 1'b0, 1'b1);
         void'(ref_capture(w, 1'b1));
         load_cmd(w);
         wait_cycles(2);
         rnd        = $urandom;
         rnd[0]     = 1'b1;
         r          = random_word();
         r.chip_sel = w.chip_sel ^ rnd[tc_geometry_pkg::SELECT_SIZE-1:0];
         r.port0.csb = 1'b1;
         r.port1.csb = 1'b1;
         load_cmd(r);
         wait_cycles(1);
         capture_check(ref_capture(r, 1'b1), "capture after rescan");
      end

      $display("Test passed");
      $finish;
   end

endmodule

//--- sram_testchip.f
src/tc_geometry_pkg.sv
src/tc_cmd_pkg.sv
src/sram_macro.sv
src/scan_cmd_reg.sv
src/read_select.sv
src/sram_testchip.sv
tests/sram_testchip_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it.
# The exit status of the simulation is the verdict.

verilator --binary --timing --assert -j 0 \
   --top-module sram_testchip_tb \
   -f sram_testchip.f \
   -o sram_testchip_sim \
   && ./obj_dir/sram_testchip_sim \
   || exit 1
